// ==== tb.f ====
+incdir+design
design/dcachePkg.sv
design/wishbonePkg.sv
design/dcacheTagStore.sv
design/dcacheMissControl.sv
design/dcacheDataStore.sv
design/dcacheTop.sv
tb/wbMemoryModel.sv
tb/dcacheTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dcacheTb
FILELIST = tb.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== tb/dcacheTb.sv ====
// cache testbench: clock, reset, stimulus, shadow-memory reference, checks and timeout
`default_nettype none
`include "dcache_defs.svh"

module dcacheTb;
    timeunit 1ns;
    timeprecision 1ps;

    import dcachePkg::*;
    import wishbonePkg::*;

    localparam int memWords = 4096;
    localparam int randomOps = 450;
    localparam int directedOps = 30;
    localparam int resetCycles = 8;
    // worst op is a writeback plus a refill with 3 waits and 2 bus cycles per word
    localparam int cyclesPerOp = 2 * `DCACHE_LINE_WORDS * (3 + 2) + 4;
    localparam int timeoutCycles = (randomOps + directedOps) * cyclesPerOp + resetCycles + 16;

    logic clock;
    logic reset;
    dcacheRequest_t request;
    logic stall;
    logic [`DCACHE_WORD_BITS-1:0] readData;
    wbSlave_t memToCache;
    wbMaster_t cacheToMem;

    logic [`DCACHE_WORD_BITS-1:0] shadowMem [memWords];
    logic [`DCACHE_WORD_BITS-1:0] expectedRead;
    int cycleCount;
    int busReadWords;
    int busWriteWords;

    dcacheTop dut (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .stall    (stall),
        .readData (readData),
        .wbIn     (memToCache),
        .wbOut    (cacheToMem)
    );

    wbMemoryModel memory (
        .clock  (clock),
        .reset  (reset),
        .busIn  (cacheToMem),
        .busOut (memToCache)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] initialWord(input logic [31:0] byteAddr);
        return (byteAddr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // architectural memory view with writes merged byte by byte
    function automatic logic [31:0] referenceAccess(input logic isWrite, input logic [31:0] addr,
            input logic [3:0] sel, input logic [31:0] data);
        logic [31:0] merged;
        merged = shadowMem[addr[13:2]];
        if (isWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (sel[lane]) begin
                    merged[8*lane +: 8] = data[8*lane +: 8];
                end
            end
            shadowMem[addr[13:2]] = merged;
        end
        return merged;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
            input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s: got %08h, expected %08h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // one request held until the cycle in which stall is low
    task automatic issueAccess(input logic isWrite, input logic [31:0] addr,
            input logic [3:0] sel, input logic [31:0] data, output int stallCycles);
        dcacheRequest_t nextRequest;
        nextRequest = '0;
        nextRequest.read = !isWrite;
        nextRequest.write = isWrite;
        nextRequest.addr = addr;
        nextRequest.byteSelect = sel;
        nextRequest.writeData = data;
        stallCycles = 0;
        @(posedge clock);
        request <= nextRequest;
        expectedRead <= referenceAccess(isWrite, addr, sel, data);
        @(negedge clock);
        while (stall) begin
            stallCycles++;
            @(negedge clock);
        end
    endtask

    always @(negedge clock) begin
        if (reset && request.read && !stall) begin
            checkValue(readData, expectedRead, "read data");
        end
    end

    // bus monitor checks every word is whole and writeback data matches the shadow
    always @(negedge clock) begin
        if (reset && cacheToMem.cyc && cacheToMem.stb && memToCache.ack) begin
            checkValue(32'(cacheToMem.sel), 32'hf, "bus byte select");
            if (cacheToMem.we) begin
                busWriteWords <= busWriteWords + 1;
                checkValue(cacheToMem.dat, shadowMem[cacheToMem.adr[13:2]], "writeback data");
            end else begin
                busReadWords <= busReadWords + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run still busy after %0d clock cycles", cycleCount);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    initial begin
        int stallCycles;
        int readsBefore;
        int writesBefore;
        void'($urandom(32'h4a54));
        clock = 1'b0;
        reset = 1'b0;
        request = '0;
        for (int i = 0; i < memWords; i++) begin
            shadowMem[i] = initialWord(32'(i) << 2);
        end
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        checkValue(32'(stall), 32'd0, "stall after reset");
        checkValue(32'(cacheToMem.cyc), 32'd0, "cyc after reset");

        // first touch of every line misses and refills
        for (int line = 0; line < `DCACHE_LINES; line++) begin
            readsBefore = busReadWords;
            issueAccess(1'b0, 32'h1004 + (32'(line) << 4), 4'hf, 32'd0, stallCycles);
            checkValue(32'(stallCycles != 0), 32'd1, "first read misses");
            checkValue(32'(busReadWords - readsBefore), 32'd4, "refill word count");
        end

        // resident line hits without stall or bus cycle
        issueAccess(1'b0, 32'h100c, 4'hf, 32'd0, stallCycles);
        checkValue(32'(stallCycles), 32'd0, "hit stall cycles");
        checkValue(32'(cacheToMem.cyc), 32'd0, "cyc during hit");

        // partial write hit then read back
        issueAccess(1'b1, 32'h1024, 4'b0110, 32'hdead_beef, stallCycles);
        checkValue(32'(stallCycles), 32'd0, "write hit stall cycles");
        issueAccess(1'b0, 32'h1024, 4'hf, 32'd0, stallCycles);

        // dirty line at index 4 is written back before the conflicting read refills
        issueAccess(1'b1, 32'h2048, 4'b0011, 32'h1234_5678, stallCycles);
        writesBefore = busWriteWords;
        readsBefore = busReadWords;
        issueAccess(1'b0, 32'h3044, 4'hf, 32'd0, stallCycles);
        checkValue(32'(busWriteWords - writesBefore), 32'd4, "writeback word count");
        checkValue(32'(busReadWords - readsBefore), 32'd4, "refill after writeback");
        issueAccess(1'b0, 32'h2048, 4'hf, 32'd0, stallCycles);

        // write miss on a clean line allocates and the write lands on the new line
        writesBefore = busWriteWords;
        readsBefore = busReadWords;
        issueAccess(1'b1, 32'h0488, 4'b1001, 32'hcafe_f00d, stallCycles);
        checkValue(32'(busWriteWords - writesBefore), 32'd0, "clean victim writeback");
        checkValue(32'(busReadWords - readsBefore), 32'd4, "write miss refill");
        issueAccess(1'b0, 32'h0488, 4'hf, 32'd0, stallCycles);
        checkValue(32'(stallCycles), 32'd0, "read after write miss");

        // 1 KB range gives four blocks per index
        for (int op = 0; op < randomOps; op++) begin
            issueAccess(1'($urandom_range(1, 0)), 32'($urandom_range(255, 0)) << 2,
                4'($urandom_range(15, 1)), $urandom(), stallCycles);
        end

        @(posedge clock);
        request <= '0;
        @(posedge clock);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/wbMemoryModel.sv ====
// Wishbone classic slave memory with random wait states and an address-derived initial pattern
`default_nettype none
`include "dcache_defs.svh"

module wbMemoryModel (
    input  logic                    clock,
    input  logic                    reset,
    input  wishbonePkg::wbMaster_t  busIn,
    output wishbonePkg::wbSlave_t   busOut
);
    timeunit 1ns;
    timeprecision 1ps;

    import wishbonePkg::*;

    localparam int memWords = 4096;
    localparam int maxWait = 3;

    logic [`DCACHE_WORD_BITS-1:0] mem [memWords];
    logic [1:0] waitLeft;
    logic [11:0] wordAddr;

    assign wordAddr = busIn.adr[13:2];

    // every bit of the byte address feeds the word
    function automatic logic [31:0] initialWord(input logic [31:0] byteAddr);
        return (byteAddr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = initialWord(32'(i) << 2);
        end
    end

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            busOut.ack <= 1'b0;
            busOut.dat <= '0;
            waitLeft <= 2'd0;
        end else if (busOut.ack) begin
            // one word per ack, then a fresh wait for the next word
            busOut.ack <= 1'b0;
            waitLeft <= 2'($urandom_range(maxWait, 0));
        end else if (busIn.cyc && busIn.stb) begin
            if (waitLeft != 2'd0) begin
                waitLeft <= waitLeft - 2'd1;
            end else begin
                busOut.ack <= 1'b1;
                if (busIn.we) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (busIn.sel[lane]) begin
                            mem[wordAddr][8*lane +: 8] <= busIn.dat[8*lane +: 8];
                        end
                    end
                end else begin
                    busOut.dat <= mem[wordAddr];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dcacheTop.sv ====
// cache top level: tag store, miss controller and data store wired to processor and bus
`default_nettype none
`include "dcache_defs.svh"

module dcacheTop (
    input  logic                          clock,
    input  logic                          reset,
    input  dcachePkg::dcacheRequest_t     request,
    output logic                          stall,
    output logic [`DCACHE_WORD_BITS-1:0]  readData,
    input  wishbonePkg::wbSlave_t         wbIn,
    output wishbonePkg::wbMaster_t        wbOut
);
    import dcachePkg::*;

    // lookup results
    logic hit;
    logic victimDirty;
    logic [`DCACHE_TAG_BITS-1:0] victimTag;

    // data store ports
    dataPort_t hitPort;
    dataPort_t fillPort;
    logic fillActive;
    logic [`DCACHE_WORD_BITS-1:0] lineWord;

    // refill completion
    logic tagUpdate;

    dcacheTagStore tagStore (
        .clock       (clock),
        .reset       (reset),
        .request     (request),
        .tagUpdate   (tagUpdate),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .hitPort     (hitPort)
    );

    dcacheMissControl missControl (
        .clock       (clock),
        .reset       (reset),
        .request     (request),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .lineWord    (lineWord),
        .wbIn        (wbIn),
        .wbOut       (wbOut),
        .fillPort    (fillPort),
        .fillActive  (fillActive),
        .tagUpdate   (tagUpdate),
        .stall       (stall)
    );

    dcacheDataStore dataStore (
        .clock      (clock),
        .hitPort    (hitPort),
        .fillPort   (fillPort),
        .fillActive (fillActive),
        .readData   (readData),
        .lineWord   (lineWord)
    );

endmodule

`default_nettype wire

// ==== design/dcacheDataStore.sv ====
// data store: line words with byte-enabled writes from two ports and word selection
`default_nettype none
`include "dcache_defs.svh"

module dcacheDataStore (
    input  logic                          clock,
    input  dcachePkg::dataPort_t          hitPort,
    input  dcachePkg::dataPort_t          fillPort,
    input  logic                          fillActive,
    output logic [`DCACHE_WORD_BITS-1:0]  readData,
    output logic [`DCACHE_WORD_BITS-1:0]  lineWord
);
    import dcachePkg::*;

    // contents are only meaningful behind a valid bit in the tag store
    logic [`DCACHE_WORD_BITS-1:0] lineData [`DCACHE_LINES][`DCACHE_LINE_WORDS];

    dataPort_t activePort;
    logic [`DCACHE_WORD_BITS-1:0] selectedWord;

    // miss controller owns the array while a miss is being handled
    assign activePort = fillActive ? fillPort : hitPort;

    always_ff @(posedge clock) begin
        if (activePort.writeEnable) begin
            for (int lane = 0; lane < `DCACHE_BYTE_LANES; lane++) begin
                if (activePort.byteEnable[lane]) begin
                    lineData[activePort.index][activePort.word][8*lane +: 8] <=
                        activePort.writeData[8*lane +: 8];
                end
            end
        end
    end

    // combinational read of the addressed word
    assign selectedWord = lineData[activePort.index][activePort.word];

    // processor read data on a hit
    assign readData = selectedWord;

    // victim word for the writeback
    assign lineWord = selectedWord;

endmodule

`default_nettype wire

// ==== design/dcacheMissControl.sv ====
// miss FSM: writeback and refill over Wishbone classic, stall generation, fill port
`default_nettype none
`include "dcache_defs.svh"

module dcacheMissControl (
    input  logic                          clock,
    input  logic                          reset,
    input  dcachePkg::dcacheRequest_t     request,
    input  logic                          hit,
    input  logic                          victimDirty,
    input  logic [`DCACHE_TAG_BITS-1:0]   victimTag,
    input  logic [`DCACHE_WORD_BITS-1:0]  lineWord,
    input  wishbonePkg::wbSlave_t         wbIn,
    output wishbonePkg::wbMaster_t        wbOut,
    output dcachePkg::dataPort_t          fillPort,
    output logic                          fillActive,
    output logic                          tagUpdate,
    output logic                          stall
);
    import dcachePkg::*;

    typedef enum logic [1:0] {
        Idle,
        Writeback,
        Done,
        MemRead
    } missState_t;

    missState_t state;
    missState_t nextState;
    logic [`DCACHE_WORD_SEL_BITS-1:0] wordCount;

    dcacheAddr_u reqAddr;
    dcacheAddr_u busAddr;
    logic miss;
    logic onBus;
    logic lastWord;

    assign reqAddr = request.addr;
    assign miss = (request.read || request.write) && !hit;
    assign onBus = (state == Writeback) || (state == MemRead);
    assign lastWord = wbIn.ack && (wordCount == `DCACHE_WORD_SEL_BITS'(`DCACHE_LINE_WORDS - 1));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (miss) begin
                    nextState = victimDirty ? Writeback : MemRead;
                end
            end
            Writeback: begin
                if (lastWord) begin
                    nextState = Done;
                end
            end
            // victim written out, cyc drops for one cycle before refill
            Done: begin
                nextState = MemRead;
            end
            MemRead: begin
                if (lastWord) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // word within the line, steps on every ack
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wordCount <= '0;
        end else if (!onBus) begin
            wordCount <= '0;
        end else if (wbIn.ack) begin
            wordCount <= wordCount + 1'b1;
        end
    end

    // bus address from the block view
    // writeback targets the victim block, refill the requested one
    always_comb begin
        busAddr = '0;
        if (state == Writeback) begin
            busAddr.blockView.block = {victimTag, reqAddr.fields.index};
        end else begin
            busAddr.blockView.block = reqAddr.blockView.block;
        end
        busAddr.blockView.offset = {wordCount, {`DCACHE_BYTE_BITS{1'b0}}};
    end

    always_comb begin
        wbOut.cyc = onBus;
        wbOut.stb = onBus;
        wbOut.we = (state == Writeback);
        wbOut.adr = busAddr;
        wbOut.sel = '1;
        wbOut.dat = (state == Writeback) ? lineWord : '0;
    end

    // fill port also addresses the victim word while writing back
    always_comb begin
        fillPort.index = reqAddr.fields.index;
        fillPort.word = wordCount;
        fillPort.byteEnable = '1;
        fillPort.writeEnable = (state == MemRead) && wbIn.ack;
        fillPort.writeData = wbIn.dat;
    end

    assign fillActive = (state != Idle);
    assign tagUpdate = (state == MemRead) && lastWord;

    // stall from the first miss cycle until the refill ends
    assign stall = (state != Idle) || miss;

    // strobe only inside a cycle, held with its address until ack
    assert property (@(posedge clock) disable iff (!reset)
        wbOut.stb |-> wbOut.cyc)
        else $error("stb without cyc");

    assert property (@(posedge clock) disable iff (!reset)
        wbOut.stb && !wbIn.ack |=> wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.we))
        else $error("master dropped its request before ack");

    assert property (@(posedge clock) disable iff (!reset)
        wbOut.cyc |-> (wbOut.adr[`DCACHE_BYTE_BITS-1:0] == '0))
        else $error("bus address not word aligned");

endmodule

`default_nettype wire

// ==== design/dcacheTagStore.sv ====
// tag store: valid, dirty and tag arrays, hit and victim detection, processor data port
`default_nettype none
`include "dcache_defs.svh"

module dcacheTagStore (
    input  logic                          clock,
    input  logic                          reset,
    input  dcachePkg::dcacheRequest_t     request,
    input  logic                          tagUpdate,
    output logic                          hit,
    output logic                          victimDirty,
    output logic [`DCACHE_TAG_BITS-1:0]   victimTag,
    output dcachePkg::dataPort_t          hitPort
);
    import dcachePkg::*;

    // per-line state
    logic [`DCACHE_LINES-1:0] validBits;
    logic [`DCACHE_LINES-1:0] dirtyBits;
    logic [`DCACHE_TAG_BITS-1:0] tagArray [`DCACHE_LINES];

    dcacheAddr_u reqAddr;
    logic [`DCACHE_INDEX_BITS-1:0] lineIndex;
    logic writeHit;

    assign reqAddr = request.addr;
    assign lineIndex = reqAddr.fields.index;

    // lookup at the indexed line
    assign hit = validBits[lineIndex] && (tagArray[lineIndex] == reqAddr.fields.tag);
    assign writeHit = request.write && hit;

    // the resident line is the one a miss would evict
    assign victimDirty = validBits[lineIndex] && dirtyBits[lineIndex];
    assign victimTag = tagArray[lineIndex];

    // processor port with byte select expanded onto the lanes only on a write hit
    always_comb begin
        hitPort.index = lineIndex;
        hitPort.word = reqAddr.fields.word;
        hitPort.byteEnable = request.byteSelect & {`DCACHE_BYTE_LANES{writeHit}};
        hitPort.writeEnable = writeHit;
        hitPort.writeData = request.writeData;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (tagUpdate) begin
            // refill finished so the line arrives clean
            validBits[lineIndex] <= 1'b1;
            dirtyBits[lineIndex] <= 1'b0;
        end else if (writeHit) begin
            dirtyBits[lineIndex] <= 1'b1;
        end
    end

    // tag written together with the valid bit
    always_ff @(posedge clock) begin
        if (tagUpdate) begin
            tagArray[lineIndex] <= reqAddr.fields.tag;
        end
    end

    // processor must never ask for both at once
    assert property (@(posedge clock) disable iff (!reset)
        !(request.read && request.write))
        else $error("read and write requested together");

endmodule

`default_nettype wire

// ==== design/wishbonePkg.sv ====
// Wishbone classic master-out and slave-out structs
`default_nettype none
`include "dcache_defs.svh"

package wishbonePkg;

    // signals driven by the master
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [`DCACHE_ADDR_BITS-1:0] adr;
        logic [`DCACHE_BYTE_LANES-1:0] sel;
        logic [`DCACHE_WORD_BITS-1:0] dat;
    } wbMaster_t;

    // signals driven by the slave
    // no err or rty, the memory always acknowledges
    typedef struct packed {
        logic ack;
        logic [`DCACHE_WORD_BITS-1:0] dat;
    } wbSlave_t;

endpackage

`default_nettype wire

// ==== design/dcachePkg.sv ====
// cache types: address union, processor request struct, data-store port struct
`default_nettype none
`include "dcache_defs.svh"

package dcachePkg;

    // tag / index / word / byte view of an address
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0] tag;
        logic [`DCACHE_INDEX_BITS-1:0] index;
        logic [`DCACHE_WORD_SEL_BITS-1:0] word;
        logic [`DCACHE_BYTE_BITS-1:0] byteOffset;
    } addrFields_t;

    // block address plus offset inside the line
    typedef struct packed {
        logic [`DCACHE_ADDR_BITS-`DCACHE_BLOCK_OFF_BITS-1:0] block;
        logic [`DCACHE_BLOCK_OFF_BITS-1:0] offset;
    } addrBlock_t;

    typedef union packed {
        addrFields_t fields;
        addrBlock_t blockView;
    } dcacheAddr_u;

    // one processor access, exactly one of read or write
    typedef struct packed {
        logic read;
        logic write;
        dcacheAddr_u addr;
        logic [`DCACHE_BYTE_LANES-1:0] byteSelect;
        logic [`DCACHE_WORD_BITS-1:0] writeData;
    } dcacheRequest_t;

    // a single word access into the data store
    typedef struct packed {
        logic [`DCACHE_INDEX_BITS-1:0] index;
        logic [`DCACHE_WORD_SEL_BITS-1:0] word;
        logic [`DCACHE_BYTE_LANES-1:0] byteEnable;
        logic writeEnable;
        logic [`DCACHE_WORD_BITS-1:0] writeData;
    } dataPort_t;

endpackage

`default_nettype wire

// ==== design/dcache_defs.svh ====
// address, word and cache geometry macros, plus the field widths derived from them
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// base sizes
`define DCACHE_ADDR_BITS 32
`define DCACHE_WORD_BITS 32
`define DCACHE_LINE_WORDS 4
`define DCACHE_LINES 16

// byte lanes in one word
`define DCACHE_BYTE_LANES (`DCACHE_WORD_BITS / 8)

// address field widths
`define DCACHE_BYTE_BITS $clog2(`DCACHE_BYTE_LANES)
`define DCACHE_WORD_SEL_BITS $clog2(`DCACHE_LINE_WORDS)
`define DCACHE_INDEX_BITS $clog2(`DCACHE_LINES)
`define DCACHE_BLOCK_OFF_BITS (`DCACHE_WORD_SEL_BITS + `DCACHE_BYTE_BITS)

// whatever is left of the address above index and block offset
`define DCACHE_TAG_BITS \
    (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - `DCACHE_BLOCK_OFF_BITS)

`endif
